// File: flist.f
+incdir+source
source/conv_pkg.sv
source/conv_multiplier.sv
source/conv_adder_tree.sv
source/conv_3x3.sv
source/conv_weight_bank.sv
source/conv_engine.sv
test/conv_engine_properties.sv
test/conv_engine_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ps \
    -f flist.f \
    --top-module conv_engine_tb \
    --Mdir obj_dir -o conv_engine_sim

./obj_dir/conv_engine_sim | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed, see sim.log"
exit 1

// File: source/conv_3x3.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_3x3 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_valid,
    input  conv_pkg::window_t   i_win,
    input  conv_pkg::window_t   i_kernel,
    input  logic                i_relu_en,
    output logic                o_valid,
    output conv_pkg::conv_out_t o_res
);

    localparam int DLY = `CONV_MULT_LAT + `CONV_TREE_LAT;
    localparam conv_pkg::acc_t S_MAX = conv_pkg::acc_t'((2 ** (`CONV_DATA_W - 1)) - 1);
    localparam conv_pkg::acc_t S_MIN = -S_MAX - 1;

    conv_pkg::window_t     prods;
    logic [`CONV_TAPS-1:0] sats;
    logic                  mult_valid;
    logic                  tree_valid;
    conv_pkg::acc_t        tree_sum;
    logic                  tree_sat;
    logic [DLY-1:0]        relu_dly;   // follows the window through the multipliers and tree.
    conv_pkg::acc_t        relu_sum;
    conv_pkg::pix_t        clip_val;
    logic                  clip_sat;

    genvar g;
    generate
        for (g = 0; g < `CONV_TAPS; g++) begin : g_mult
            if (g == 0) begin : g_lead
                conv_multiplier mult_i (
                    .clk(clk), .rst_n(rst_n), .i_valid(i_valid),
                    .i_a(i_win[g]), .i_b(i_kernel[g]),
                    .o_valid(mult_valid), .o_prod(prods[g]), .o_sat(sats[g])
                );
            end else begin : g_rest
                // the lanes run in lockstep, lane 0 carries the valid.
                conv_multiplier mult_i (
                    .clk(clk), .rst_n(rst_n), .i_valid(i_valid),
                    .i_a(i_win[g]), .i_b(i_kernel[g]),
                    .o_valid(), .o_prod(prods[g]), .o_sat(sats[g])
                );
            end
        end
    endgenerate

    conv_adder_tree tree_i (
        .clk(clk), .rst_n(rst_n), .i_valid(mult_valid),
        .i_prods(prods), .i_sats(sats),
        .o_valid(tree_valid), .o_sum(tree_sum), .o_sat(tree_sat)
    );

    always_comb begin
        relu_sum = (relu_dly[DLY-1] && tree_sum < 0) ? '0 : tree_sum;
        clip_val = relu_sum[`CONV_DATA_W-1:0];
        clip_sat = 1'b0;
        if (relu_sum > S_MAX) begin
            clip_val = S_MAX[`CONV_DATA_W-1:0];
            clip_sat = 1'b1;
        end else if (relu_sum < S_MIN) begin
            clip_val = S_MIN[`CONV_DATA_W-1:0];
            clip_sat = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            relu_dly <= '0;
            o_valid  <= 1'b0;
            o_res    <= '0;
        end else begin
            relu_dly <= {relu_dly[DLY-2:0], i_relu_en};
            o_valid  <= tree_valid;
            if (tree_valid) begin
                o_res <= '{sat: tree_sat | clip_sat, value: clip_val};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/conv_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_adder_tree (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_valid,
    input  conv_pkg::window_t      i_prods,
    input  logic [`CONV_TAPS-1:0]  i_sats,
    output logic                   o_valid,
    output conv_pkg::acc_t         o_sum,
    output logic                   o_sat
);

    conv_pkg::acc_t ext [9];
    conv_pkg::acc_t s1  [5];
    conv_pkg::acc_t s2  [3];
    conv_pkg::acc_t s3  [2];
    logic [4:0]     sat1;
    logic [2:0]     sat2;
    logic [1:0]     sat3;
    logic [`CONV_TREE_LAT-1:0] valid_sr;

    always_comb begin
        for (int k = 0; k < 9; k++) begin
            ext[k] = conv_pkg::acc_t'(signed'(i_prods[k]));
        end
    end

    // 9 -> 5 -> 3 -> 2 -> 1, the odd element is carried forward.
    always_ff @(posedge clk) begin
        for (int k = 0; k < 4; k++) begin
            s1[k]   <= ext[2*k] + ext[2*k+1];
            sat1[k] <= i_sats[2*k] | i_sats[2*k+1];
        end
        s1[4]   <= ext[8];
        sat1[4] <= i_sats[8];

        s2[0]   <= s1[0] + s1[1];
        s2[1]   <= s1[2] + s1[3];
        s2[2]   <= s1[4];
        sat2[0] <= sat1[0] | sat1[1];
        sat2[1] <= sat1[2] | sat1[3];
        sat2[2] <= sat1[4];

        s3[0]   <= s2[0] + s2[1];
        s3[1]   <= s2[2];
        sat3[0] <= sat2[0] | sat2[1];
        sat3[1] <= sat2[2];

        o_sum <= s3[0] + s3[1];
        o_sat <= sat3[0] | sat3[1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[`CONV_TREE_LAT-2:0], i_valid};
        end
    end

    assign o_valid = valid_sr[`CONV_TREE_LAT-1];

endmodule

`default_nettype wire

// File: source/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// Q8.8 pixels and weights.
`define CONV_DATA_W 16
`define CONV_FRAC_W 8

`define CONV_TAPS 9

// nine saturated 16-bit products fit in 20 bits.
`define CONV_ACC_W 20

// pipeline depths in clock cycles.
`define CONV_MULT_LAT 2
`define CONV_TREE_LAT 4
`define CONV_LAT (`CONV_MULT_LAT + `CONV_TREE_LAT + 1)

`endif

// File: source/conv_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_win_valid,
    input  conv_pkg::window_t   i_win,
    input  logic                i_relu_en,
    input  logic                i_w_we,
    input  logic [3:0]          i_w_idx,
    input  conv_pkg::pix_t      i_w_data,
    output logic                o_res_valid,
    output conv_pkg::conv_out_t o_res
);

    conv_pkg::window_t kernel;   // read by every window as it enters.

    conv_weight_bank weight_bank_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_we     (i_w_we),
        .i_idx    (i_w_idx),
        .i_data   (i_w_data),
        .o_kernel (kernel)
    );

    conv_3x3 conv_3x3_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_valid   (i_win_valid),
        .i_win     (i_win),
        .i_kernel  (kernel),
        .i_relu_en (i_relu_en),
        .o_valid   (o_res_valid),
        .o_res     (o_res)
    );

endmodule

`default_nettype wire

// File: source/conv_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_multiplier (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_valid,
    input  conv_pkg::pix_t i_a,
    input  conv_pkg::pix_t i_b,
    output logic           o_valid,
    output conv_pkg::pix_t o_prod,
    output logic           o_sat
);

    localparam int PW = 2 * `CONV_DATA_W;
    localparam logic signed [PW-1:0] P_MAX = PW'((2 ** (`CONV_DATA_W - 1)) - 1);
    localparam logic signed [PW-1:0] P_MIN = -P_MAX - 1;

    logic signed [PW-1:0] prod_q;    // full precision product, Q16.16.
    logic signed [PW-1:0] prod_shr;
    conv_pkg::pix_t       prod_clip;
    logic                 clip_sat;
    logic                 valid_q;

    // arithmetic shift truncates toward minus infinity.
    always_comb begin
        prod_shr  = prod_q >>> `CONV_FRAC_W;
        prod_clip = prod_shr[`CONV_DATA_W-1:0];
        clip_sat  = 1'b0;
        if (prod_shr > P_MAX) begin
            prod_clip = P_MAX[`CONV_DATA_W-1:0];
            clip_sat  = 1'b1;
        end else if (prod_shr < P_MIN) begin
            prod_clip = P_MIN[`CONV_DATA_W-1:0];
            clip_sat  = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= i_a * i_b;
        o_prod <= prod_clip;
        o_sat  <= clip_sat;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            valid_q <= i_valid;
            o_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

// File: source/conv_pkg.sv
`default_nettype none

`include "conv_config.svh"

package conv_pkg;

    // signed Q8.8 value, shared by pixels, weights and products.
    typedef logic signed [`CONV_DATA_W-1:0] pix_t;

    // tap 0 sits in the lowest bits.
    typedef pix_t [`CONV_TAPS-1:0] window_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // one finished window.
    typedef struct packed {
        logic sat;   // set when any product or the final sum was clipped.
        pix_t value;
    } conv_out_t;

endpackage

`default_nettype wire

// File: source/conv_weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_weight_bank (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_we,
    input  logic [3:0]        i_idx,
    input  conv_pkg::pix_t    i_data,
    output conv_pkg::window_t o_kernel
);

    logic idx_ok;

    // indices 9 to 15 have no register behind them.
    assign idx_ok = (i_idx < 4'(`CONV_TAPS));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_kernel <= '0;
        end else if (i_we && idx_ok) begin
            o_kernel[i_idx] <= i_data;   // other taps hold their value.
        end
    end

endmodule

`default_nettype wire

// File: test/conv_engine_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_engine_properties (
    input logic                                        clk,
    input logic                                        rst_n,
    input logic                                        i_in_valid,
    input logic                                        i_out_valid,
    input conv_pkg::conv_out_t                         i_res,
    input logic [`CONV_MULT_LAT+`CONV_TREE_LAT-1:0]    i_relu_dly
);

    localparam int DLY = `CONV_MULT_LAT + `CONV_TREE_LAT;

    assert property (@(posedge clk) !rst_n |-> !i_out_valid)
        else $error("result valid raised while in reset");

    // every accepted window leaves after the full pipeline depth.
    assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid == $past(i_in_valid, `CONV_LAT))
        else $error("result valid does not follow window valid by the pipeline latency");

    // the last delay tap is registered into the output one cycle later.
    assert property (@(posedge clk) disable iff (!rst_n)
        i_out_valid && $past(i_relu_dly[DLY-1]) |-> !i_res.value[`CONV_DATA_W-1])
        else $error("negative result while ReLU was enabled");

endmodule

bind conv_3x3 conv_engine_properties props_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_in_valid  (i_valid),
    .i_out_valid (o_valid),
    .i_res       (o_res),
    .i_relu_dly  (relu_dly)
);

`default_nettype wire

// File: test/conv_engine_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_config.svh"

module conv_engine_tb;

    localparam int CLK_NS     = 4;
    localparam int RST_CYCLES = 10;
    localparam int N_ROWS     = 11;
    localparam int N_RAND     = 40;
    localparam int TEST_CYCLES = `CONV_TAPS + `CONV_LAT + 4;   // kernel load, window, drain.
    localparam int WATCH_NS = 2 * CLK_NS * (RST_CYCLES + (N_ROWS + 6) * TEST_CYCLES
                                            + N_RAND + `CONV_TAPS + `CONV_LAT);

    typedef struct packed {
        conv_pkg::conv_out_t res;
        logic [31:0]         cycle;   // cycle count when the window was driven.
    } pending_t;

    typedef struct {
        string               name;
        conv_pkg::window_t   w;
        conv_pkg::window_t   p;
        logic                relu;
        conv_pkg::conv_out_t res;
    } row_t;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                i_win_valid;
    conv_pkg::window_t   i_win;
    logic                i_relu_en;
    logic                i_w_we;
    logic [3:0]          i_w_idx;
    conv_pkg::pix_t      i_w_data;
    logic                o_res_valid;
    conv_pkg::conv_out_t o_res;

    pending_t          pending[$];
    row_t              rows[$];
    conv_pkg::window_t shadow;          // what the weight bank should hold.
    logic [31:0]       cycle = 0;
    logic [31:0]       lfsr = 32'd99824;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                test_errs = 0;

    conv_engine conv_engine_i (.*);

    always #(CLK_NS / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[14:0], lfsr[0]};
        end
        return r;
    endfunction

    // sign extends n random bits to a full Q8.8 value.
    function automatic conv_pkg::pix_t rand_pix(input int n);
        conv_pkg::pix_t v;
        v = conv_pkg::pix_t'(rand_bits(n) << (16 - n));
        return v >>> (16 - n);
    endfunction

    function automatic longint clip16(input longint v, inout logic sat);
        if (v > 32767) begin
            sat = 1'b1;
            return 32767;
        end else if (v < -32768) begin
            sat = 1'b1;
            return -32768;
        end
        return v;
    endfunction

    function automatic conv_pkg::conv_out_t model(input conv_pkg::window_t w,
                                                  input conv_pkg::window_t p, input logic relu);
        conv_pkg::conv_out_t r;
        longint sum;
        logic   sat;
        sum = 0;
        sat = 1'b0;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            sum += clip16((longint'(signed'(w[k])) * longint'(signed'(p[k]))) >>> `CONV_FRAC_W,
                          sat);
        end
        if (relu && sum < 0) sum = 0;
        sum = clip16(sum, sat);
        r.sat   = sat;
        r.value = conv_pkg::pix_t'(sum);
        return r;
    endfunction

    function automatic conv_pkg::window_t ramp();
        conv_pkg::window_t w;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            w[k] = conv_pkg::pix_t'((k + 1) * 64);   // 0.25, 0.5 ... 2.25
        end
        return w;
    endfunction

    function automatic conv_pkg::window_t one_tap(input int idx, input conv_pkg::pix_t val);
        conv_pkg::window_t w;
        w = '0;
        w[idx] = val;
        return w;
    endfunction

    function automatic conv_pkg::window_t alternate(input conv_pkg::pix_t a,
                                                    input conv_pkg::pix_t b);
        conv_pkg::window_t w;
        for (int k = 0; k < `CONV_TAPS; k++) begin
            w[k] = (k % 2 == 0) ? a : b;
        end
        return w;
    endfunction

    function automatic void add_row(input string name, input conv_pkg::window_t w,
                                    input conv_pkg::window_t p, input logic relu,
                                    input int val, input logic sat);
        row_t r;
        r.name      = name;
        r.w         = w;
        r.p         = p;
        r.relu      = relu;
        r.res.value = conv_pkg::pix_t'(val);
        r.res.sat   = sat;
        rows.push_back(r);
    endfunction

    task automatic compare(input logic signed [63:0] got, input logic signed [63:0] exp,
                           input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_edge();
        @(negedge clk);
        i_win_valid = 1'b0;
        i_w_we      = 1'b0;
    endtask

    task automatic set_weight(input logic [3:0] idx, input conv_pkg::pix_t data);
        i_w_we   = 1'b1;
        i_w_idx  = idx;
        i_w_data = data;
        if (idx < `CONV_TAPS) shadow[idx] = data;
    endtask

    task automatic set_window(input conv_pkg::window_t win, input logic relu,
                              input conv_pkg::conv_out_t res);
        i_win_valid = 1'b1;
        i_win       = win;
        i_relu_en   = relu;
        pending.push_back('{res: res, cycle: cycle});
    endtask

    task automatic load_kernel(input conv_pkg::window_t k);
        for (int t = 0; t < `CONV_TAPS; t++) begin
            next_edge();
            set_weight(4'(t), k[t]);
        end
    endtask

    task automatic drain();
        while (pending.size() != 0) next_edge();
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %-16s %s", name, (errors == test_errs) ? "ok" : "FAIL");
        test_errs = errors;
    endtask

    always @(negedge clk) begin : monitor
        pending_t e;
        if (rst_n && o_res_valid) begin
            if (pending.size() == 0) begin
                errors++;
                $display("Error: a result arrived at %0t ns with no window outstanding.", $time);
            end else begin
                e = pending.pop_front();
                compare(o_res.value, e.res.value, "result value");
                compare(o_res.sat, e.res.sat, "result sat");
                compare(cycle - e.cycle, `CONV_LAT, "result latency");
            end
        end
    end

    initial begin : watchdog
        #(WATCH_NS);
        $display("Error: the run timed out after %0d ns.", WATCH_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        conv_pkg::window_t win;
        logic [15:0]       r1;
        rst_n       = 1'b0;
        i_win_valid = 1'b0;
        i_win       = '0;
        i_relu_en   = 1'b0;
        i_w_we      = 1'b0;
        i_w_idx     = '0;
        i_w_data    = '0;
        shadow      = '0;

        add_row("identity", one_tap(4, 16'sh0100), ramp(), 1'b0, 320, 1'b0);
        add_row("box_sum", {`CONV_TAPS{16'sh0100}}, ramp(), 1'b0, 2880, 1'b0);
        add_row("mixed_trunc", alternate(16'sh0080, 16'shFF80), {`CONV_TAPS{16'sh0003}},
                1'b0, -3, 1'b0);
        add_row("zero_window", {`CONV_TAPS{16'sh0100}}, '0, 1'b0, 0, 1'b0);
        add_row("relu_neg_off", {`CONV_TAPS{16'sh0100}}, {`CONV_TAPS{16'shFF00}},
                1'b0, -2304, 1'b0);
        add_row("relu_neg_on", {`CONV_TAPS{16'sh0100}}, {`CONV_TAPS{16'shFF00}},
                1'b1, 0, 1'b0);
        add_row("relu_pos_on", {`CONV_TAPS{16'sh0100}}, ramp(), 1'b1, 2880, 1'b0);
        add_row("prod_sat", one_tap(0, 16'sh7F00), one_tap(0, 16'sh7F00), 1'b0, 32767, 1'b1);
        add_row("sum_max", {`CONV_TAPS{16'sh7F00}}, {`CONV_TAPS{16'sh7F00}}, 1'b0, 32767, 1'b1);
        add_row("sum_clip", {`CONV_TAPS{16'sh0100}}, {`CONV_TAPS{16'sh7000}}, 1'b0, 32767, 1'b1);
        add_row("neg_clip", {`CONV_TAPS{16'sh0100}}, {`CONV_TAPS{16'sh9000}},
                1'b0, -32768, 1'b1);

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        repeat (4) begin
            next_edge();
            compare(o_res_valid, 0, "valid after reset");
            compare(o_res, 0, "result after reset");
        end
        next_edge();
        set_window(ramp(), 1'b0, '0);   // weights are still all zero.
        drain();
        finish_test("reset");

        foreach (rows[r]) begin
            load_kernel(rows[r].w);
            next_edge();
            set_window(rows[r].p, rows[r].relu, rows[r].res);
            drain();
            finish_test(rows[r].name);
        end

        load_kernel({`CONV_TAPS{16'sh0100}});
        next_edge();
        set_window(ramp(), 1'b0, model(shadow, ramp(), 1'b0));
        next_edge();
        set_weight(4'd9, 16'sh4000);
        next_edge();
        set_weight(4'd15, 16'sh4000);
        next_edge();
        set_window(ramp(), 1'b0, model(shadow, ramp(), 1'b0));
        next_edge();
        set_window(ramp(), 1'b0, model(shadow, ramp(), 1'b0));   // sampled with the old tap 3.
        set_weight(4'd3, 16'shFE00);
        next_edge();
        set_window(ramp(), 1'b0, model(shadow, ramp(), 1'b0));
        drain();
        finish_test("weight_bank");

        for (int k = 0; k < `CONV_TAPS; k++) begin
            next_edge();
            set_weight(4'(k), rand_pix(14));
        end
        for (int n = 0; n < N_RAND; n++) begin
            next_edge();
            for (int k = 0; k < `CONV_TAPS; k++) begin
                win[k] = rand_pix(12);
            end
            r1 = rand_bits(1);
            set_window(win, r1[0], model(shadow, win, r1[0]));
        end
        drain();
        finish_test("random_pipeline");

        next_edge();
        $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
